// File: ps2_pkg.sv
`default_nettype none

package ps2_pkg;

  localparam int NUM_KEYS = 12;

  typedef logic [3:0] key_idx_t;

  // key indices, same order as the held bitmap
  localparam key_idx_t KEY_Q = 4'd0;
  localparam key_idx_t KEY_W = 4'd1;
  localparam key_idx_t KEY_E = 4'd2;
  localparam key_idx_t KEY_A = 4'd3;
  localparam key_idx_t KEY_S = 4'd4;
  localparam key_idx_t KEY_D = 4'd5;
  localparam key_idx_t KEY_U = 4'd6;
  localparam key_idx_t KEY_J = 4'd7;
  localparam key_idx_t KEY_I = 4'd8;
  localparam key_idx_t KEY_K = 4'd9;
  localparam key_idx_t KEY_O = 4'd10;
  localparam key_idx_t KEY_L = 4'd11;

  // per key: bit 0 press pulse, bit 1 release pulse
  typedef struct packed {
    logic       pressed;   // any make parsed
    logic       released;  // any break parsed
    logic [1:0] q, w, e, a, s, d, u, j, i, k, o, l;
  } keys_t;

  typedef struct packed {
    logic     rel;
    key_idx_t idx;
  } key_evt_t;

  // wishbone word addresses
  localparam logic [1:0] REG_STATUS = 2'd0;
  localparam logic [1:0] REG_EVENT  = 2'd1;
  localparam logic [1:0] REG_HELD   = 2'd2;
  localparam logic [1:0] REG_CTRL   = 2'd3;

  localparam int STAT_EMPTY   = 4;   // count sits in bits 3:0
  localparam int STAT_FERR    = 5;
  localparam int STAT_OVF     = 6;
  localparam int EVT_EMPTY    = 31;
  localparam int CTRL_CLR_ERR = 0;
  localparam int CTRL_FLUSH   = 1;

  // gathers press (sel=0) or release (sel=1) pulses into an indexed vector
  function automatic logic [NUM_KEYS-1:0] key_vec(keys_t kv, logic sel);
    logic [NUM_KEYS-1:0] v;
    v        = '0;
    v[KEY_Q] = kv.q[sel];
    v[KEY_W] = kv.w[sel];
    v[KEY_E] = kv.e[sel];
    v[KEY_A] = kv.a[sel];
    v[KEY_S] = kv.s[sel];
    v[KEY_D] = kv.d[sel];
    v[KEY_U] = kv.u[sel];
    v[KEY_J] = kv.j[sel];
    v[KEY_I] = kv.i[sel];
    v[KEY_K] = kv.k[sel];
    v[KEY_O] = kv.o[sel];
    v[KEY_L] = kv.l[sel];
    return v;
  endfunction

endpackage

`default_nettype wire

// File: ps2_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
  input  logic       clk,
  input  logic       rst_b,
  input  logic       ps2_clk_i,   // async, idles high
  input  logic       ps2_data_i,  // async
  output logic [7:0] byte_o,
  output logic       byte_vld_o,
  output logic       frame_err_o
);

  logic [1:0]  ck_s;       // keyboard clock synchroniser
  logic [1:0]  dat_s;      // keyboard data synchroniser
  logic        ck_d;       // delayed copy for edge detect
  logic        fall;
  logic [3:0]  bit_cnt;
  logic [10:0] shreg;      // {stop, parity, data[7:0], start}
  logic        frame_rdy;
  logic        frame_ok;

  // two flop synchronisers, reset to the idle level so no false edge
  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      ck_s  <= 2'b11;
      dat_s <= 2'b11;
      ck_d  <= 1'b1;
    end else begin
      ck_s  <= {ck_s[0], ps2_clk_i};
      dat_s <= {dat_s[0], ps2_data_i};
      ck_d  <= ck_s[1];
    end
  end

  assign fall = ck_d & ~ck_s[1];

  // lsb first, so shift in from the top
  always_ff @(posedge clk) begin
    if (fall) begin
      shreg <= {dat_s[1], shreg[10:1]};
    end
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      bit_cnt   <= 4'd0;
      frame_rdy <= 1'b0;
    end else begin
      frame_rdy <= fall && (bit_cnt == 4'd10);  // stop bit just sampled
      if (fall) begin
        if (bit_cnt == 4'd10) begin
          bit_cnt <= 4'd0;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  // start low, stop high, odd parity over data plus parity bit
  assign frame_ok = ~shreg[0] & shreg[10] & (^shreg[9:1]);

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      byte_vld_o  <= 1'b0;
      frame_err_o <= 1'b0;
    end else begin
      byte_vld_o  <= frame_rdy & frame_ok;
      frame_err_o <= frame_rdy & ~frame_ok;  // bad byte never reaches the parser
    end
  end

  always_ff @(posedge clk) begin
    if (frame_rdy) begin
      byte_o <= shreg[8:1];
    end
  end

endmodule

`default_nettype wire

// File: ps2_parse.sv
`timescale 1ns/1ps
`default_nettype none

// make:  XX    or E0 XX
// break: F0 XX or E0 F0 XX
module ps2_parse import ps2_pkg::*; (
  input  logic       clk,
  input  logic       rst_b,
  input  logic [7:0] ps2_pkt_dh_i,
  input  logic       rec_ps2_pkt_i,
  output keys_t      keys_o
);

  typedef enum logic [1:0] {IDLE, E0, F0} state_t;

  state_t     cs, ns;
  logic       is_e0, is_f0;
  logic       e0_seen, f0_seen;
  logic       set_e0, set_f0;
  logic       parse_pkt;
  logic [1:0] key_code;   // {release, press}
  keys_t      keys_n;

  assign is_e0 = (ps2_pkt_dh_i == 8'hE0);
  assign is_f0 = (ps2_pkt_dh_i == 8'hF0);

  // prefixes are only taken where the sequence allows them
  assign set_e0    = rec_ps2_pkt_i & is_e0 & (cs == IDLE);
  assign set_f0    = rec_ps2_pkt_i & is_f0 & ((cs == IDLE) | (cs == E0));
  assign parse_pkt = rec_ps2_pkt_i & ~set_e0 & ~set_f0;

  always_comb begin
    ns = cs;
    case (cs)
      IDLE: begin
        if (set_e0) begin
          ns = E0;
        end else if (set_f0) begin
          ns = F0;
        end
      end
      E0: begin
        if (set_f0) begin
          ns = F0;
        end else if (parse_pkt) begin
          ns = IDLE;
        end
      end
      F0: begin
        if (parse_pkt) begin
          ns = IDLE;
        end
      end
      default: ns = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      cs <= IDLE;
    end else begin
      cs <= ns;
    end
  end

  // flags hold the prefix context until the final byte
  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      e0_seen <= 1'b0;
      f0_seen <= 1'b0;
    end else if (parse_pkt) begin
      e0_seen <= 1'b0;
      f0_seen <= 1'b0;
    end else begin
      if (set_e0) e0_seen <= 1'b1;
      if (set_f0) f0_seen <= 1'b1;
    end
  end

  assign key_code = {f0_seen, ~f0_seen};

  always_comb begin
    keys_n = '0;
    if (parse_pkt) begin
      keys_n.pressed  = ~f0_seen;
      keys_n.released = f0_seen;
      // e0 in the top bit keeps extended codes off the game keys
      case ({e0_seen, ps2_pkt_dh_i})
        9'h015:  keys_n.q = key_code;
        9'h01D:  keys_n.w = key_code;
        9'h024:  keys_n.e = key_code;
        9'h01C:  keys_n.a = key_code;
        9'h01B:  keys_n.s = key_code;
        9'h023:  keys_n.d = key_code;
        9'h03C:  keys_n.u = key_code;
        9'h03B:  keys_n.j = key_code;
        9'h043:  keys_n.i = key_code;
        9'h042:  keys_n.k = key_code;
        9'h044:  keys_n.o = key_code;
        9'h04B:  keys_n.l = key_code;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      keys_o <= '0;
    end else begin
      keys_o <= keys_n;   // one cycle pulse
    end
  end

endmodule

`default_nettype wire

// File: key_event_queue.sv
`timescale 1ns/1ps
`default_nettype none

module key_event_queue import ps2_pkg::*; #(
  parameter int FIFO_DEPTH = 8   // power of two
) (
  input  logic       clk,
  input  logic       rst_b,
  input  keys_t      keys_i,
  input  logic       pop_i,
  input  logic       flush_i,
  output key_evt_t   head_o,
  output logic [3:0] count_o,
  output logic       empty_o,
  output logic       overflow_o
);

  localparam int AW = $clog2(FIFO_DEPTH);

  key_evt_t            mem [FIFO_DEPTH];
  logic [AW:0]         wr_ptr, rd_ptr;   // extra bit tells full from empty
  logic [NUM_KEYS-1:0] press, rel, act;
  key_evt_t            evt;
  logic                push, full;

  assign press = key_vec(keys_i, 1'b0);
  assign rel   = key_vec(keys_i, 1'b1);
  assign act   = press | rel;
  assign push  = |act;

  // lowest index wins, though only one key fires per cycle
  always_comb begin
    evt.rel = |rel;
    evt.idx = '0;
    for (int n = NUM_KEYS - 1; n >= 0; n--) begin
      if (act[n]) evt.idx = key_idx_t'(n);
    end
  end

  assign empty_o = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign count_o = 4'(wr_ptr - rd_ptr);
  assign head_o  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (push && !full && !flush_i) begin
      mem[wr_ptr[AW-1:0]] <= evt;
    end
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      overflow_o <= 1'b0;
    end else begin
      overflow_o <= push & full;   // event dropped
      if (flush_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        if (push && !full) wr_ptr <= wr_ptr + 1'b1;
        if (pop_i && !empty_o) rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: kbd_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_wb_regs import ps2_pkg::*; (
  input  logic        clk,
  input  logic        rst_b,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  input  keys_t       keys_i,
  input  logic        frame_err_i,
  input  key_evt_t    head_i,
  input  logic [3:0]  count_i,
  input  logic        empty_i,
  input  logic        overflow_i,
  output logic        pop_o,
  output logic        flush_o
);

  logic                req;        // new request, not yet acked
  logic                wr_ctrl;
  logic [NUM_KEYS-1:0] held;
  logic                ferr_q, ovf_q;
  logic [31:0]         rd_mux;

  assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_ctrl = req & wb_we_i & (wb_adr_i == REG_CTRL);

  always_comb begin
    rd_mux = '0;
    case (wb_adr_i)
      REG_STATUS: begin
        rd_mux[3:0]        = count_i;
        rd_mux[STAT_EMPTY] = empty_i;
        rd_mux[STAT_FERR]  = ferr_q;
        rd_mux[STAT_OVF]   = ovf_q;
      end
      REG_EVENT: begin
        rd_mux            = 32'(head_i);
        rd_mux[EVT_EMPTY] = empty_i;
      end
      REG_HELD: rd_mux = 32'(held);
      default:  rd_mux = '0;   // ctrl bits are write-one pulses
    endcase
  end

  // ack, pop and flush all land in the same cycle
  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      wb_ack_o <= 1'b0;
      pop_o    <= 1'b0;
      flush_o  <= 1'b0;
    end else begin
      wb_ack_o <= req;
      pop_o    <= req & ~wb_we_i & (wb_adr_i == REG_EVENT) & ~empty_i;
      flush_o  <= wr_ctrl & wb_dat_i[CTRL_FLUSH];
    end
  end

  always_ff @(posedge clk) begin
    if (req && !wb_we_i) begin
      wb_dat_o <= rd_mux;
    end
  end

  // new errors win over a clear in the same cycle
  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      ferr_q <= 1'b0;
      ovf_q  <= 1'b0;
    end else begin
      ferr_q <= frame_err_i | (ferr_q & ~(wr_ctrl & wb_dat_i[CTRL_CLR_ERR]));
      ovf_q  <= overflow_i | (ovf_q & ~(wr_ctrl & wb_dat_i[CTRL_CLR_ERR]));
    end
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      held <= '0;
    end else begin
      held <= (held | key_vec(keys_i, 1'b0)) & ~key_vec(keys_i, 1'b1);
    end
  end

endmodule

`default_nettype wire

// File: kbd_top.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_top import ps2_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic        clk,
  input  logic        rst_b,
  input  logic        ps2_clk_i,
  input  logic        ps2_data_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o
);

  logic [7:0] rx_byte;
  logic       rx_vld;
  logic       frame_err;
  keys_t      keys;
  key_evt_t   head;
  logic [3:0] count;
  logic       empty, overflow;
  logic       pop, flush;

  ps2_rx u_rx (
    .clk         (clk),
    .rst_b       (rst_b),
    .ps2_clk_i   (ps2_clk_i),
    .ps2_data_i  (ps2_data_i),
    .byte_o      (rx_byte),
    .byte_vld_o  (rx_vld),
    .frame_err_o (frame_err)
  );

  ps2_parse u_parse (
    .clk           (clk),
    .rst_b         (rst_b),
    .ps2_pkt_dh_i  (rx_byte),
    .rec_ps2_pkt_i (rx_vld),
    .keys_o        (keys)
  );

  key_event_queue #(.FIFO_DEPTH(FIFO_DEPTH)) u_queue (
    .clk        (clk),
    .rst_b      (rst_b),
    .keys_i     (keys),
    .pop_i      (pop),
    .flush_i    (flush),
    .head_o     (head),
    .count_o    (count),
    .empty_o    (empty),
    .overflow_o (overflow)
  );

  kbd_wb_regs u_regs (
    .clk         (clk),
    .rst_b       (rst_b),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .keys_i      (keys),
    .frame_err_i (frame_err),
    .head_i      (head),
    .count_i     (count),
    .empty_i     (empty),
    .overflow_i  (overflow),
    .pop_o       (pop),
    .flush_o     (flush)
  );

endmodule

`default_nettype wire

// File: kbd_chk.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_chk (
  input logic clk,
  input logic rst_b,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic pop_i,
  input logic empty_i
);

  int unsigned err_cnt = 0;   // failed assertions so far

  // ack is a single clock pulse in a classic cycle
  a_ack_pulse: assert property (
    @(posedge clk) disable iff (!rst_b) ack_i |=> !ack_i
  ) else begin
    err_cnt++;
    $error("wishbone ack stayed high for more than one cycle");
  end

  a_ack_req: assert property (
    @(posedge clk) disable iff (!rst_b) ack_i |-> $past(cyc_i && stb_i)
  ) else begin
    err_cnt++;
    $error("wishbone ack without a request in the previous cycle");
  end

  a_pop_nonempty: assert property (
    @(posedge clk) disable iff (!rst_b) pop_i |-> !empty_i
  ) else begin
    err_cnt++;
    $error("queue pop while the queue is empty");
  end

endmodule

`default_nettype wire

// File: tb_kbd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_kbd import ps2_pkg::*; ();

  localparam int HALF     = 8;                // system clocks per ps2 half period
  localparam int NUM_ROWS = 13;
  localparam int WATCHDOG = NUM_ROWS * 1500;  // clocks

  // held bitmap bits in index order q w e a s d u j i k o l
  localparam logic [11:0] H_Q = 12'h001;
  localparam logic [11:0] H_A = 12'h008;
  localparam logic [11:0] H_U = 12'h040;
  localparam logic [11:0] H_L = 12'h800;

  // q w e a s d u j i make codes in index order 0..8
  localparam logic [71:0] FILL = 72'h15_1D_24_1C_1B_23_3C_3B_43;

  typedef struct {
    string       name;
    int          nb;        // scan bytes used with the first in bits 23:16
    logic [23:0] seq;
    logic        bad;       // wrong parity on the last byte
    logic        has_evt;
    key_evt_t    evt;
    logic [11:0] held;
  } row_t;

  logic        clk;
  logic        rst_b;
  logic        ps2_clk, ps2_data;
  logic        wb_cyc, wb_stb, wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w, wb_dat_r;
  logic        wb_ack;
  logic [15:0] lfsr_q;
  row_t        rows [NUM_ROWS];

  kbd_top #(.FIFO_DEPTH(8)) uut (
    .clk        (clk),
    .rst_b      (rst_b),
    .ps2_clk_i  (ps2_clk),
    .ps2_data_i (ps2_data),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack)
  );

  bind kbd_wb_regs kbd_chk u_chk (
    .clk     (clk),
    .rst_b   (rst_b),
    .cyc_i   (wb_cyc_i),
    .stb_i   (wb_stb_i),
    .ack_i   (wb_ack_o),
    .pop_i   (pop_o),
    .empty_i (empty_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    abort_run($sformatf("watchdog expired, run still busy after %0d clocks", WATCHDOG));
  end

  // any failed bus or queue assertion ends the run
  initial begin
    wait (uut.u_regs.u_chk.err_cnt != 0);
    abort_run("an assertion in the wishbone and queue checker failed");
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // device model sends start, data lsb first, odd parity and stop
  task automatic send_byte(input logic [7:0] data, input logic bad_par);
    logic [10:0] frame;
    int          gap;
    frame = {1'b1, (~^data) ^ bad_par, data, 1'b0};
    @(posedge clk);
    for (int n = 0; n < 11; n++) begin
      ps2_data <= frame[n];
      repeat (HALF) @(posedge clk);
      ps2_clk <= 1'b0;              // receiver samples on this edge
      repeat (HALF) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    ps2_data <= 1'b1;
    gap = 0;
    for (int n = 0; n < 4; n++) begin
      gap    = (gap << 1) | lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
    repeat (20 + gap) @(posedge clk);
  endtask

  task automatic wb_xfer(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                         output logic [31:0] rdat);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 10) abort_run("no wishbone ack within 10 clocks of the request");
    end while (!wb_ack);
    check("wishbone ack latency", 32'd2, waited);
    rdat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic set_row(input int r, input string name, input int nb, input logic [23:0] seq,
                         input logic bad, input logic has_evt, input logic rel,
                         input key_idx_t idx, input logic [11:0] held);
    rows[r].name    = name;
    rows[r].nb      = nb;
    rows[r].seq     = seq;
    rows[r].bad     = bad;
    rows[r].has_evt = has_evt;
    rows[r].evt     = {rel, idx};
    rows[r].held    = held;
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] exp_stat;
    lfsr_q   = 16'd32807;
    rst_b    = 1'b0;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = 2'd0;
    wb_dat_w = 32'd0;

    set_row(0,  "make a",        1, 24'h1C0000, 0, 1, 0, KEY_A, H_A);
    set_row(1,  "break a",       2, 24'hF01C00, 0, 1, 1, KEY_A, 12'h000);
    set_row(2,  "ext make",      2, 24'hE01500, 0, 0, 0, 4'd0,  12'h000);
    set_row(3,  "ext break",     3, 24'hE0F015, 0, 0, 0, 4'd0,  12'h000);
    set_row(4,  "unknown make",  1, 24'h290000, 0, 0, 0, 4'd0,  12'h000);
    set_row(5,  "bad parity",    1, 24'h1D0000, 1, 0, 0, 4'd0,  12'h000);
    set_row(6,  "press q",       1, 24'h150000, 0, 1, 0, KEY_Q, H_Q);
    set_row(7,  "press l",       1, 24'h4B0000, 0, 1, 0, KEY_L, H_Q | H_L);
    set_row(8,  "press u",       1, 24'h3C0000, 0, 1, 0, KEY_U, H_Q | H_L | H_U);
    set_row(9,  "release l",     2, 24'hF04B00, 0, 1, 1, KEY_L, H_Q | H_U);
    set_row(10, "release q",     2, 24'hF01500, 0, 1, 1, KEY_Q, H_U);
    set_row(11, "release u",     2, 24'hF03C00, 0, 1, 1, KEY_U, 12'h000);
    set_row(12, "unknown break", 2, 24'hF02900, 0, 0, 0, 4'd0,  12'h000);

    repeat (8) @(posedge clk);
    rst_b <= 1'b1;
    repeat (4) @(posedge clk);

    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int n = 0; n < rows[r].nb; n++) begin
        send_byte(rows[r].seq[23 - 8*n -: 8], rows[r].bad && (n == rows[r].nb - 1));
      end
      repeat (40) @(posedge clk);
      // ovf, ferr, empty, count
      exp_stat = {25'd0, 1'b0, rows[r].bad, !rows[r].has_evt, 3'd0, rows[r].has_evt};
      wb_xfer(1'b0, REG_STATUS, 32'd0, rd);
      check({rows[r].name, " status"}, exp_stat, rd);
      wb_xfer(1'b0, REG_EVENT, 32'd0, rd);
      if (rows[r].has_evt) begin
        check({rows[r].name, " event"}, {27'd0, rows[r].evt}, rd);
      end else begin
        check({rows[r].name, " event empty flag"}, 32'd1, {31'd0, rd[31]});
      end
      wb_xfer(1'b0, REG_HELD, 32'd0, rd);
      check({rows[r].name, " held"}, {20'd0, rows[r].held}, rd);
      if (rows[r].bad) begin
        wb_xfer(1'b1, REG_CTRL, 32'h1, rd);
        wb_xfer(1'b0, REG_STATUS, 32'd0, rd);
        check({rows[r].name, " error clear"}, 32'h10, rd);
      end
    end

    // fill past the queue depth so the ninth event is dropped
    for (int n = 0; n < 9; n++) begin
      send_byte(FILL[71 - 8*n -: 8], 1'b0);
    end
    repeat (40) @(posedge clk);
    wb_xfer(1'b0, REG_STATUS, 32'd0, rd);
    check("overflow status", 32'h48, rd);
    for (int n = 0; n < 8; n++) begin
      wb_xfer(1'b0, REG_EVENT, 32'd0, rd);
      check($sformatf("overflow pop %0d", n), {27'd0, 1'b0, 4'(n)}, rd);
    end
    wb_xfer(1'b0, REG_STATUS, 32'd0, rd);
    check("drained status", 32'h50, rd);

    send_byte(8'h42, 1'b0);   // k
    send_byte(8'h44, 1'b0);   // o
    repeat (40) @(posedge clk);
    wb_xfer(1'b0, REG_STATUS, 32'd0, rd);
    check("refill status", 32'h42, rd);
    wb_xfer(1'b1, REG_CTRL, 32'h2, rd);
    wb_xfer(1'b0, REG_STATUS, 32'd0, rd);
    check("flush status", 32'h50, rd);
    wb_xfer(1'b0, REG_HELD, 32'd0, rd);
    check("held after flush", 32'h7FF, rd);
    wb_xfer(1'b1, REG_CTRL, 32'h1, rd);
    wb_xfer(1'b0, REG_STATUS, 32'd0, rd);
    check("overflow clear", 32'h10, rd);

    @(negedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
ps2_pkg.sv
ps2_rx.sv
ps2_parse.sv
key_event_queue.sv
kbd_wb_regs.sv
kbd_top.sv
kbd_chk.sv
tb_kbd.sv
